/* rtl/dla_pkg.sv */
`default_nettype none

package dla_pkg;

    // PE array geometry, channels per tile on each side
    localparam int unsigned PE_ROWS = 32;   // Input channels per tile
    localparam int unsigned PE_COLS = 32;   // Output channels per tile

    localparam int ADDR_W = 32;             // DMA address and length
    localparam int DIM_W  = 8;              // Spatial size
    localparam int CH_W   = 11;             // Channel count
    localparam int TILE_W = 6;              // Tile index and tile count

    // Fixed byte addresses of the global buffer regions
    localparam logic [ADDR_W-1:0] GLB_IFMAP_BASE  = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] GLB_WEIGHT_BASE = 32'h0004_0000;
    localparam logic [ADDR_W-1:0] GLB_OPSUM_BASE  = 32'h0006_0000;

    typedef enum logic [1:0] {
        LT_PW  = 2'd0,                      // Pointwise, 1x1
        LT_DW  = 2'd1,                      // Depthwise 3x3
        LT_STD = 2'd2,                      // Standard 3x3
        LT_LIN = 2'd3                       // Fully connected
    } layer_type_e;

    // Which transfer the DMA generator forms
    typedef enum logic [1:0] {
        DK_IFMAP  = 2'd0,
        DK_WEIGHT = 2'd1,
        DK_OFMAP  = 2'd2
    } dma_kind_e;

endpackage

`default_nettype wire

/* rtl/dla_ifs.sv */
`timescale 1ns/10ps
`default_nettype none

interface layer_if;
    logic                         valid;       // Descriptor held, layer in flight
    dla_pkg::layer_type_e         layer_type;
    logic [1:0]                   k_size;      // 1 or 3
    logic [dla_pkg::DIM_W-1:0]    out_r;
    logic [dla_pkg::DIM_W-1:0]    out_c;
    logic [dla_pkg::DIM_W-1:0]    in_r;
    logic [dla_pkg::DIM_W-1:0]    in_c;
    logic [dla_pkg::CH_W-1:0]     in_d;
    logic [dla_pkg::TILE_W-1:0]   tile_d_n;    // Input-channel tiles
    logic [dla_pkg::TILE_W-1:0]   tile_k_n;    // Output-channel tiles
    logic [dla_pkg::ADDR_W-1:0]   base_ifmap;
    logic [dla_pkg::ADDR_W-1:0]   base_weight;
    logic [dla_pkg::ADDR_W-1:0]   base_ofmap;

    modport src (output valid, layer_type, k_size, out_r, out_c, in_r, in_c, in_d,
                 tile_d_n, tile_k_n, base_ifmap, base_weight, base_ofmap);
    modport dst (input valid, layer_type, k_size, out_r, out_c, in_r, in_c, in_d,
                 tile_d_n, tile_k_n, base_ifmap, base_weight, base_ofmap);
endinterface

interface tile_if;
    logic                         clear;       // Restart both indices
    logic                         step;        // Advance to next tile
    logic [dla_pkg::TILE_W-1:0]   d_idx;
    logic [dla_pkg::TILE_W-1:0]   k_idx;
    logic                         last_d;
    logic                         last_tile;

    modport ctrl (output clear, step, input d_idx, k_idx, last_d, last_tile);
    modport cnt (input clear, step, output d_idx, k_idx, last_d, last_tile);
endinterface

`default_nettype wire

/* rtl/layer_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module layer_decoder (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          uld_en_i,
    input  dla_pkg::layer_type_e          layer_type_i,
    input  logic [dla_pkg::DIM_W-1:0]     in_r_i,
    input  logic [dla_pkg::DIM_W-1:0]     in_c_i,
    input  logic [dla_pkg::CH_W-1:0]      in_d_i,
    input  logic [dla_pkg::CH_W-1:0]      out_k_i,
    input  logic [1:0]                    stride_i,
    input  logic [1:0]                    pad_t_i,
    input  logic [1:0]                    pad_b_i,
    input  logic [1:0]                    pad_l_i,
    input  logic [1:0]                    pad_r_i,
    input  logic [dla_pkg::ADDR_W-1:0]    base_ifmap_i,
    input  logic [dla_pkg::ADDR_W-1:0]    base_weight_i,
    input  logic [dla_pkg::ADDR_W-1:0]    base_ofmap_i,
    input  logic                          layer_done_i,
    layer_if.src                          ld
);

    logic                         take;
    logic [1:0]                   k_size_w;
    logic [dla_pkg::DIM_W:0]      span_r;      // Padded height minus kernel
    logic [dla_pkg::DIM_W:0]      span_c;
    logic [dla_pkg::DIM_W:0]      quot_r;
    logic [dla_pkg::DIM_W:0]      quot_c;
    logic [dla_pkg::CH_W-1:0]     d_tiles;
    logic [dla_pkg::CH_W-1:0]     k_tiles;

    // A descriptor in the same cycle as layer done starts the next layer
    assign take = uld_en_i && (!ld.valid || layer_done_i);

    always_comb begin
        case (layer_type_i)
            dla_pkg::LT_PW, dla_pkg::LT_LIN: k_size_w = 2'd1;
            default:                         k_size_w = 2'd3;
        endcase
    end

    assign span_r = {1'b0, in_r_i} + {{(dla_pkg::DIM_W-1){1'b0}}, pad_t_i}
                  + {{(dla_pkg::DIM_W-1){1'b0}}, pad_b_i}
                  - {{(dla_pkg::DIM_W-1){1'b0}}, k_size_w};
    assign span_c = {1'b0, in_c_i} + {{(dla_pkg::DIM_W-1){1'b0}}, pad_l_i}
                  + {{(dla_pkg::DIM_W-1){1'b0}}, pad_r_i}
                  - {{(dla_pkg::DIM_W-1){1'b0}}, k_size_w};
    assign quot_r = (stride_i == 2'd2) ? (span_r >> 1) : span_r;   // Stride is 1 or 2
    assign quot_c = (stride_i == 2'd2) ? (span_c >> 1) : span_c;

    // Ceiling division by the array size
    assign d_tiles = (in_d_i >> $clog2(dla_pkg::PE_ROWS))
                   + {{(dla_pkg::CH_W-1){1'b0}}, |in_d_i[$clog2(dla_pkg::PE_ROWS)-1:0]};
    assign k_tiles = (out_k_i >> $clog2(dla_pkg::PE_COLS))
                   + {{(dla_pkg::CH_W-1){1'b0}}, |out_k_i[$clog2(dla_pkg::PE_COLS)-1:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld.valid <= 1'b0;
        end else if (take) begin
            ld.valid <= 1'b1;
        end else if (layer_done_i) begin
            ld.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ld.layer_type  <= layer_type_i;
            ld.k_size      <= k_size_w;
            ld.in_r        <= in_r_i;
            ld.in_c        <= in_c_i;
            ld.in_d        <= in_d_i;
            ld.out_r       <= quot_r[dla_pkg::DIM_W-1:0] + 1'b1;
            ld.out_c       <= quot_c[dla_pkg::DIM_W-1:0] + 1'b1;
            ld.tile_d_n    <= d_tiles[dla_pkg::TILE_W-1:0];
            ld.tile_k_n    <= (layer_type_i == dla_pkg::LT_DW) ?
                              {{(dla_pkg::TILE_W-1){1'b0}}, 1'b1} :  // One group, channels in place
                              k_tiles[dla_pkg::TILE_W-1:0];
            ld.base_ifmap  <= base_ifmap_i;
            ld.base_weight <= base_weight_i;
            ld.base_ofmap  <= base_ofmap_i;
        end
    end

    a_stride_legal: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> (stride_i == 2'd1 || stride_i == 2'd2));

endmodule

`default_nettype wire

/* rtl/tile_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_counter (
    input  logic                          clk,
    input  logic                          rst_n,
    tile_if.cnt                           tc,
    input  logic [dla_pkg::TILE_W-1:0]    tile_d_n_i,
    input  logic [dla_pkg::TILE_W-1:0]    tile_k_n_i
);

    logic [dla_pkg::TILE_W-1:0] d_max;
    logic [dla_pkg::TILE_W-1:0] k_max;

    assign d_max = tile_d_n_i - 1'b1;
    assign k_max = tile_k_n_i - 1'b1;

    assign tc.last_d    = (tc.d_idx == d_max);
    assign tc.last_tile = tc.last_d && (tc.k_idx == k_max);

    // d is the inner loop, k the outer one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tc.d_idx <= '0;
            tc.k_idx <= '0;
        end else if (tc.clear) begin
            tc.d_idx <= '0;
            tc.k_idx <= '0;
        end else if (tc.step) begin
            if (tc.last_d) begin
                tc.d_idx <= '0;               // Wrap into next output group
                tc.k_idx <= tc.k_idx + 1'b1;
            end else begin
                tc.d_idx <= tc.d_idx + 1'b1;
            end
        end
    end

    a_no_step_past_end: assert property (@(posedge clk) disable iff (!rst_n)
        tc.step |-> !tc.last_tile);

endmodule

`default_nettype wire

/* rtl/dma_cmd_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module dma_cmd_gen (
    input  dla_pkg::dma_kind_e            kind_i,
    layer_if.dst                          ld,
    input  logic [dla_pkg::TILE_W-1:0]    d_idx_i,
    input  logic [dla_pkg::TILE_W-1:0]    k_idx_i,
    output logic                          dma_read_o,
    output logic [dla_pkg::ADDR_W-1:0]    dma_src_o,
    output logic [dla_pkg::ADDR_W-1:0]    dma_dest_o,
    output logic [dla_pkg::ADDR_W-1:0]    dma_len_o
);

    logic [dla_pkg::ADDR_W-1:0] ks_x;
    logic [dla_pkg::ADDR_W-1:0] d_x;
    logic [dla_pkg::ADDR_W-1:0] k_x;
    logic [dla_pkg::ADDR_W-1:0] nd_x;
    logic [dla_pkg::ADDR_W-1:0] ifm_len;
    logic [dla_pkg::ADDR_W-1:0] wlen;         // One weight tile
    logic [dla_pkg::ADDR_W-1:0] olen;         // One output-channel group
    logic [dla_pkg::ADDR_W-1:0] w_src;
    logic [dla_pkg::ADDR_W-1:0] o_dest;

    assign ks_x = {{(dla_pkg::ADDR_W-2){1'b0}}, ld.k_size};
    assign d_x  = {{(dla_pkg::ADDR_W-dla_pkg::TILE_W){1'b0}}, d_idx_i};
    assign k_x  = {{(dla_pkg::ADDR_W-dla_pkg::TILE_W){1'b0}}, k_idx_i};
    assign nd_x = {{(dla_pkg::ADDR_W-dla_pkg::TILE_W){1'b0}}, ld.tile_d_n};

    assign ifm_len = {{(dla_pkg::ADDR_W-dla_pkg::DIM_W){1'b0}}, ld.in_r}
                   * {{(dla_pkg::ADDR_W-dla_pkg::DIM_W){1'b0}}, ld.in_c}
                   * {{(dla_pkg::ADDR_W-dla_pkg::CH_W){1'b0}}, ld.in_d};
    assign wlen    = ks_x * ks_x * dla_pkg::PE_ROWS * dla_pkg::PE_COLS;
    assign olen    = {{(dla_pkg::ADDR_W-dla_pkg::DIM_W){1'b0}}, ld.out_r}
                   * {{(dla_pkg::ADDR_W-dla_pkg::DIM_W){1'b0}}, ld.out_c}
                   * dla_pkg::PE_COLS;

    // Weights are stored k-major in DRAM, outputs one group after another
    assign w_src  = ld.base_weight + (k_x * nd_x + d_x) * wlen;
    assign o_dest = ld.base_ofmap + k_x * olen;

    always_comb begin
        dma_read_o = 1'b1;
        dma_src_o  = ld.base_ifmap;
        dma_dest_o = dla_pkg::GLB_IFMAP_BASE;
        dma_len_o  = ifm_len;
        case (kind_i)
            dla_pkg::DK_WEIGHT: begin
                dma_src_o  = w_src;
                dma_dest_o = dla_pkg::GLB_WEIGHT_BASE;
                dma_len_o  = wlen;
            end
            dla_pkg::DK_OFMAP: begin
                dma_read_o = 1'b0;            // Write back to DRAM
                dma_src_o  = dla_pkg::GLB_OPSUM_BASE;
                dma_dest_o = o_dest;
                dma_len_o  = olen;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/tile_scheduler_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module tile_scheduler_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    layer_if.dst                  ld,
    tile_if.ctrl                  tc,
    input  logic                  dma_done_i,
    input  logic                  pass_done_i,
    output dla_pkg::dma_kind_e    dma_kind_o,
    output logic                  dma_valid_o,
    output logic                  pass_start_o,
    output logic                  layer_done_o,
    output logic                  busy_o
);

    typedef enum logic [3:0] {
        IDLE, LOAD_IFMAP, WAIT_IFMAP, LOAD_W, WAIT_W,
        PASS, WAIT_PASS, STORE, WAIT_STORE, DONE
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   cmd_pending;                      // DMA command issued, not yet answered

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (ld.valid) state_nxt = LOAD_IFMAP;
            LOAD_IFMAP: state_nxt = WAIT_IFMAP;
            WAIT_IFMAP: if (dma_done_i) state_nxt = LOAD_W;
            LOAD_W:     state_nxt = WAIT_W;
            WAIT_W:     if (dma_done_i) state_nxt = PASS;
            PASS:       state_nxt = WAIT_PASS;
            WAIT_PASS:  if (pass_done_i) state_nxt = tc.last_d ? STORE : LOAD_W;
            STORE:      state_nxt = WAIT_STORE;
            WAIT_STORE: if (dma_done_i) state_nxt = tc.last_tile ? DONE : LOAD_W;
            DONE:       state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    // Kind stays put through the wait so the command fields hold
    always_comb begin
        case (state)
            IDLE, LOAD_IFMAP, WAIT_IFMAP: dma_kind_o = dla_pkg::DK_IFMAP;
            STORE, WAIT_STORE, DONE:      dma_kind_o = dla_pkg::DK_OFMAP;
            default:                      dma_kind_o = dla_pkg::DK_WEIGHT;
        endcase
    end

    assign dma_valid_o  = (state == LOAD_IFMAP) || (state == LOAD_W) || (state == STORE);
    assign pass_start_o = (state == PASS);
    assign layer_done_o = (state == DONE);
    assign busy_o       = ld.valid && (state != DONE);   // Drops with layer done

    assign tc.clear = (state == IDLE);
    assign tc.step  = (state == WAIT_PASS && pass_done_i && !tc.last_d)
                   || (state == WAIT_STORE && dma_done_i && !tc.last_tile);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_pending <= 1'b0;
        end else if (dma_valid_o) begin
            cmd_pending <= 1'b1;
        end else if (dma_done_i) begin
            cmd_pending <= 1'b0;
        end
    end

    a_one_cmd_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        dma_valid_o |-> !cmd_pending);

    // Idle means no descriptor held by the decoder
    a_no_pass_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_o |-> !pass_start_o);

    // Depthwise keeps all channels in one group, so its write-back ends the layer
    a_dw_single_group: assert property (@(posedge clk) disable iff (!rst_n)
        (state == STORE && ld.layer_type == dla_pkg::LT_DW) |-> tc.last_tile);

endmodule

`default_nettype wire

/* rtl/dla_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module dla_controller (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          uld_en_i,
    input  dla_pkg::layer_type_e          layer_type_i,
    input  logic [dla_pkg::DIM_W-1:0]     in_r_i,
    input  logic [dla_pkg::DIM_W-1:0]     in_c_i,
    input  logic [dla_pkg::CH_W-1:0]      in_d_i,
    input  logic [dla_pkg::CH_W-1:0]      out_k_i,
    input  logic [1:0]                    stride_i,
    input  logic [1:0]                    pad_t_i,
    input  logic [1:0]                    pad_b_i,
    input  logic [1:0]                    pad_l_i,
    input  logic [1:0]                    pad_r_i,
    input  logic [dla_pkg::ADDR_W-1:0]    base_ifmap_i,
    input  logic [dla_pkg::ADDR_W-1:0]    base_weight_i,
    input  logic [dla_pkg::ADDR_W-1:0]    base_ofmap_i,
    input  logic                          dma_done_i,
    input  logic                          pass_done_i,
    output logic                          dma_valid_o,
    output logic                          dma_read_o,
    output logic [dla_pkg::ADDR_W-1:0]    dma_src_o,
    output logic [dla_pkg::ADDR_W-1:0]    dma_dest_o,
    output logic [dla_pkg::ADDR_W-1:0]    dma_len_o,
    output logic                          pass_start_o,
    output logic [dla_pkg::TILE_W-1:0]    pass_k_o,
    output logic [dla_pkg::TILE_W-1:0]    pass_d_o,
    output logic                          layer_done_o,
    output logic                          busy_o
);

    dla_pkg::dma_kind_e dma_kind;

    layer_if ld_if ();
    tile_if  t_if ();

    layer_decoder u_decoder (
        .clk(clk), .rst_n(rst_n), .uld_en_i(uld_en_i), .layer_type_i(layer_type_i),
        .in_r_i(in_r_i), .in_c_i(in_c_i), .in_d_i(in_d_i), .out_k_i(out_k_i),
        .stride_i(stride_i),
        .pad_t_i(pad_t_i), .pad_b_i(pad_b_i), .pad_l_i(pad_l_i), .pad_r_i(pad_r_i),
        .base_ifmap_i(base_ifmap_i), .base_weight_i(base_weight_i),
        .base_ofmap_i(base_ofmap_i),
        .layer_done_i(layer_done_o),          // Frees the descriptor
        .ld(ld_if)
    );

    tile_counter u_counter (
        .clk(clk), .rst_n(rst_n), .tc(t_if),
        .tile_d_n_i(ld_if.tile_d_n), .tile_k_n_i(ld_if.tile_k_n)
    );

    tile_scheduler_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .ld(ld_if), .tc(t_if),
        .dma_done_i(dma_done_i), .pass_done_i(pass_done_i),
        .dma_kind_o(dma_kind), .dma_valid_o(dma_valid_o), .pass_start_o(pass_start_o),
        .layer_done_o(layer_done_o), .busy_o(busy_o)
    );

    dma_cmd_gen u_dma_gen (
        .kind_i(dma_kind), .ld(ld_if), .d_idx_i(t_if.d_idx), .k_idx_i(t_if.k_idx),
        .dma_read_o(dma_read_o), .dma_src_o(dma_src_o),
        .dma_dest_o(dma_dest_o), .dma_len_o(dma_len_o)
    );

    assign pass_k_o = t_if.k_idx;             // Held by the counter until pass done
    assign pass_d_o = t_if.d_idx;

endmodule

`default_nettype wire

/* test/tb_dla_controller.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_dla_controller;

    localparam int LAYERS  = 20;
    localparam int TIMEOUT = 2000;                // Cycles per wait

    logic                          clk;
    logic                          rst_n;
    logic                          uld_en_i;
    dla_pkg::layer_type_e          layer_type_i;
    logic [dla_pkg::DIM_W-1:0]     in_r_i;
    logic [dla_pkg::DIM_W-1:0]     in_c_i;
    logic [dla_pkg::CH_W-1:0]      in_d_i;
    logic [dla_pkg::CH_W-1:0]      out_k_i;
    logic [1:0]                    stride_i;
    logic [1:0]                    pad_t_i;
    logic [1:0]                    pad_b_i;
    logic [1:0]                    pad_l_i;
    logic [1:0]                    pad_r_i;
    logic [dla_pkg::ADDR_W-1:0]    base_ifmap_i;
    logic [dla_pkg::ADDR_W-1:0]    base_weight_i;
    logic [dla_pkg::ADDR_W-1:0]    base_ofmap_i;
    logic                          dma_done_i;
    logic                          pass_done_i;
    logic                          dma_valid_o;
    logic                          dma_read_o;
    logic [dla_pkg::ADDR_W-1:0]    dma_src_o;
    logic [dla_pkg::ADDR_W-1:0]    dma_dest_o;
    logic [dla_pkg::ADDR_W-1:0]    dma_len_o;
    logic                          pass_start_o;
    logic [dla_pkg::TILE_W-1:0]    pass_k_o;
    logic [dla_pkg::TILE_W-1:0]    pass_d_o;
    logic                          layer_done_o;
    logic                          busy_o;

    int dma_cnt  = 0;
    int pass_cnt = 0;
    int done_cnt = 0;

    dla_controller DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Pulse counters, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && dma_valid_o) dma_cnt++;
        if (rst_n && pass_start_o) pass_cnt++;
        if (rst_n && layer_done_o) done_cnt++;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("** Error at %0t ns: %s", $time, msg));
    endtask

    task automatic draw_descriptor();
        layer_type_i  = dla_pkg::layer_type_e'(2'($urandom_range(0, 3)));
        in_r_i        = 8'($urandom_range(3, 40));
        in_c_i        = 8'($urandom_range(3, 40));
        in_d_i        = 11'($urandom_range(1, 100));
        out_k_i       = 11'($urandom_range(1, 100));
        stride_i      = 2'($urandom_range(1, 2));
        pad_t_i       = 2'($urandom_range(0, 2));
        pad_b_i       = 2'($urandom_range(0, 2));
        pad_l_i       = 2'($urandom_range(0, 2));
        pad_r_i       = 2'($urandom_range(0, 2));
        base_ifmap_i  = $urandom() & 32'hffff_fffc;   // Word aligned
        base_weight_i = $urandom() & 32'hffff_fffc;
        base_ofmap_i  = $urandom() & 32'hffff_fffc;
    endtask

    task automatic send_done(input bit is_pass);
        @(posedge clk);
        #1;
        if (is_pass) pass_done_i = 1'b1;
        else dma_done_i = 1'b1;
        @(posedge clk);
        #1;
        pass_done_i = 1'b0;
        dma_done_i  = 1'b0;
    endtask

    task automatic expect_dma(input logic rd, input logic [31:0] src, input logic [31:0] dst,
                              input logic [31:0] len, input int limit);
        int waited;
        int hold;
        waited = 0;
        @(negedge clk);
        while (!dma_valid_o) begin
            assert (!pass_start_o && !layer_done_o)
                else value_error("pass start or layer done while a DMA command was due");
            waited++;
            if (waited >= limit) abort_run($sformatf("No DMA command within %0d cycles", limit));
            @(negedge clk);
        end
        assert (dma_read_o == rd && dma_src_o == src && dma_dest_o == dst && dma_len_o == len)
            else value_error($sformatf("DMA rd %0b src %h dest %h len %0d, expected %0b %h %h %0d",
                dma_read_o, dma_src_o, dma_dest_o, dma_len_o, rd, src, dst, len));
        hold = $urandom_range(1, 8);
        repeat (hold) begin
            @(negedge clk);
            assert (!dma_valid_o && dma_src_o == src && dma_dest_o == dst && dma_len_o == len)
                else value_error("DMA command fields changed before done");
        end
        send_done(1'b0);
    endtask

    task automatic expect_pass(input int k, input int d, input bit poke);
        int waited;
        int hold;
        waited = 0;
        @(negedge clk);
        while (!pass_start_o) begin
            assert (!dma_valid_o) else value_error("DMA command while a pass start was due");
            waited++;
            if (waited >= TIMEOUT) abort_run("No pass start within the timeout");
            @(negedge clk);
        end
        assert (pass_k_o == k && pass_d_o == d)
            else value_error($sformatf("pass k %0d d %0d, expected k %0d d %0d",
                pass_k_o, pass_d_o, k, d));
        if (poke) begin                           // Descriptor while busy must be dropped
            assert (busy_o) else value_error("busy low during a pass");
            @(posedge clk);
            #1;
            draw_descriptor();
            uld_en_i = 1'b1;
            @(posedge clk);
            #1;
            uld_en_i = 1'b0;
        end
        hold = $urandom_range(1, 8);
        repeat (hold) begin
            @(negedge clk);
            assert (!pass_start_o && !dma_valid_o && pass_k_o == k && pass_d_o == d)
                else value_error("pass indices changed or extra pulse before pass done");
        end
        send_done(1'b1);
    endtask

    initial begin
        int unsigned ks;
        int unsigned o_r;
        int unsigned o_c;
        int unsigned nd;
        int unsigned nk;
        int unsigned wlen;
        int unsigned olen;
        int unsigned ifm_len;
        int unsigned b_w;
        int unsigned b_o;
        int unsigned b_if;
        int          exp_cmds;
        int          exp_passes;
        void'($urandom(32'hc4c83577));
        exp_cmds    = 0;
        exp_passes  = 0;
        rst_n       = 1'b0;
        uld_en_i    = 1'b0;
        dma_done_i  = 1'b0;
        pass_done_i = 1'b0;
        draw_descriptor();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (8) begin
            @(negedge clk);
            assert (!busy_o && !dma_valid_o && !pass_start_o && !layer_done_o)
                else value_error("outputs active with no descriptor");
        end
        for (int l = 0; l < LAYERS; l++) begin
            @(posedge clk);
            #1;
            draw_descriptor();
            uld_en_i = 1'b1;
            ks   = (layer_type_i == dla_pkg::LT_PW || layer_type_i == dla_pkg::LT_LIN) ? 1 : 3;
            o_r  = (in_r_i + pad_t_i + pad_b_i - ks) / stride_i + 1;
            o_c  = (in_c_i + pad_l_i + pad_r_i - ks) / stride_i + 1;
            nd   = (in_d_i + dla_pkg::PE_ROWS - 1) / dla_pkg::PE_ROWS;
            nk   = (layer_type_i == dla_pkg::LT_DW) ? 1 :
                   (out_k_i + dla_pkg::PE_COLS - 1) / dla_pkg::PE_COLS;
            wlen = ks * ks * dla_pkg::PE_ROWS * dla_pkg::PE_COLS;
            olen = o_r * o_c * dla_pkg::PE_COLS;
            ifm_len = in_r_i * in_c_i * in_d_i;
            b_if = base_ifmap_i;
            b_w  = base_weight_i;
            b_o  = base_ofmap_i;
            exp_cmds   += 1 + nk * (nd + 1);
            exp_passes += nk * nd;
            @(posedge clk);
            #1;
            uld_en_i = 1'b0;
            @(negedge clk);
            assert (busy_o && !dma_valid_o) else value_error("busy or command timing wrong");
            expect_dma(1'b1, b_if, dla_pkg::GLB_IFMAP_BASE, ifm_len, 1);   // Two cycles after
            for (int k = 0; k < nk; k++) begin
                for (int d = 0; d < nd; d++) begin
                    expect_dma(1'b1, b_w + (k * nd + d) * wlen, dla_pkg::GLB_WEIGHT_BASE,
                               wlen, TIMEOUT);
                    expect_pass(k, d, (k == 0 && d == 0));
                end
                expect_dma(1'b0, dla_pkg::GLB_OPSUM_BASE, b_o + k * olen, olen, TIMEOUT);
            end
            @(negedge clk);
            assert (layer_done_o && !busy_o) else value_error("layer done missing after final done");
            @(negedge clk);
            assert (!layer_done_o) else value_error("layer done longer than one cycle");
            @(posedge clk);
            #1;
            assert (done_cnt == l + 1) else value_error("layer done count wrong");
        end
        @(posedge clk);
        #1;
        assert (dma_cnt == exp_cmds && pass_cnt == exp_passes && done_cnt == LAYERS)
            $display("TESTS PASSED");
        else value_error($sformatf("counts dma %0d pass %0d, expected %0d %0d",
            dma_cnt, pass_cnt, exp_cmds, exp_passes));
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
rtl/dla_pkg.sv
rtl/dla_ifs.sv
rtl/layer_decoder.sv
rtl/tile_counter.sv
rtl/dma_cmd_gen.sv
rtl/tile_scheduler_fsm.sv
rtl/dla_controller.sv
test/tb_dla_controller.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dla_controller \
		-f compile.f --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
